// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rename_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+hw
hw/rename_pkg.sv
hw/inst_decode.sv
hw/map_table.sv
hw/reorder_buffer.sv
hw/rename_top.sv
dv/rename_tb.sv

// File: dv/rename_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int clk_period    = 8;
    localparam int reset_cycles  = 4;
    localparam int margin_cycles = 20;

    // Source status encodings.
    localparam int rf = 'b00;
    localparam int wt = 'b10;
    localparam int rd = 'b11;

    typedef struct {
        int inst_valid;
        int inst;
        int cdb_valid;
        int cdb_tag;
        int stall;
        int illegal;
        int s1_stat;
        int s1_tag;
        int s2_stat;
        int s2_tag;
        int out_tag;
        int out_dest;
        int commit_valid;
        int commit_reg;
        int commit_tag;
    } row_t;

    logic                     clk;
    logic                     reset;
    logic                     inst_valid;
    logic [15:0]              inst;
    logic                     cdb_valid;
    logic [`ROB_TAG_LEN-1:0]  cdb_tag;
    logic                     stall;
    logic                     illegal;
    data_stat_t               src1_stat;
    logic [`ROB_TAG_LEN-1:0]  src1_tag;
    data_stat_t               src2_stat;
    logic [`ROB_TAG_LEN-1:0]  src2_tag;
    logic [`REG_ADDR_LEN-1:0] out_dest;
    logic [`ROB_TAG_LEN-1:0]  out_tag;
    logic                     commit_valid;
    logic [`REG_ADDR_LEN-1:0] commit_reg;
    logic [`ROB_TAG_LEN-1:0]  commit_tag;

    row_t rows[$];
    bit   table_ready;
    int   cur_row;

    rename_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .stall        (stall),
        .illegal      (illegal),
        .src1_stat    (src1_stat),
        .src1_tag     (src1_tag),
        .src2_stat    (src2_stat),
        .src2_tag     (src2_tag),
        .out_dest     (out_dest),
        .out_tag      (out_tag),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic void add_row(input int iv, input int in, input int cv, input int ct,
                                    input int st, input int il, input int s1s, input int s1t,
                                    input int s2s, input int s2t, input int ot, input int od,
                                    input int cmv, input int cmr, input int cmt);
        row_t r;
        r.inst_valid   = iv;
        r.inst         = in;
        r.cdb_valid    = cv;
        r.cdb_tag      = ct;
        r.stall        = st;
        r.illegal      = il;
        r.s1_stat      = s1s;
        r.s1_tag       = s1t;
        r.s2_stat      = s2s;
        r.s2_tag       = s2t;
        r.out_tag      = ot;
        r.out_dest     = od;
        r.commit_valid = cmv;
        r.commit_reg   = cmr;
        r.commit_tag   = cmt;
        rows.push_back(r);
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s in row %0d: got %h, expected %h", name, cur_row, actual,
                     expected);
            $display("=== FAIL ===");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic apply_row(input row_t r);
        inst_valid = r.inst_valid[0];
        inst       = r.inst[15:0];
        cdb_valid  = r.cdb_valid[0];
        cdb_tag    = r.cdb_tag[`ROB_TAG_LEN-1:0];
    endtask

    task automatic check_row(input row_t r);
        check("stall", 32'(stall), r.stall);
        check("illegal", 32'(illegal), r.illegal);
        check("src1_stat", 32'(src1_stat), r.s1_stat);
        check("src1_tag", 32'(src1_tag), r.s1_tag);
        check("src2_stat", 32'(src2_stat), r.s2_stat);
        check("src2_tag", 32'(src2_tag), r.s2_tag);
        check("out_tag", 32'(out_tag), r.out_tag);
        check("out_dest", 32'(out_dest), r.out_dest);
        check("commit_valid", 32'(commit_valid), r.commit_valid);
        if (r.commit_valid != 0) begin // Commit fields mean nothing while idle.
            check("commit_reg", 32'(commit_reg), r.commit_reg);
            check("commit_tag", 32'(commit_tag), r.commit_tag);
        end
    endtask

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        reset      = 1'b1;
        cur_row    = 0;

        // Reset state first. Then r3 takes tag 0 and goes through broadcast and commit.
        add_row(0, 'h0000, 0, 0, 0, 0, rf, 7, rf, 7, 0, 0, 0, 0, 0);
        add_row(1, 'h3056, 0, 0, 0, 0, rf, 7, rf, 7, 0, 0, 0, 0, 0);
        add_row(1, 'h1312, 0, 0, 0, 0, rf, 7, rf, 7, 0, 3, 0, 0, 0);
        add_row(1, 'h1431, 0, 0, 0, 0, wt, 0, rf, 7, 1, 4, 0, 0, 0);
        add_row(1, 'h2540, 1, 0, 0, 0, wt, 1, rf, 7, 2, 5, 0, 0, 0);
        add_row(1, 'h3035, 0, 0, 0, 0, rd, 0, wt, 2, 3, 0, 1, 3, 0);
        add_row(1, 'h3034, 0, 0, 0, 0, rf, 7, wt, 1, 3, 0, 0, 0, 0);
        // Two writers of r6. The older commit must not unmap the newer one.
        add_row(1, 'h1600, 0, 0, 0, 0, rf, 7, rf, 7, 3, 6, 0, 0, 0);
        add_row(1, 'h1660, 0, 0, 0, 0, wt, 3, rf, 7, 4, 6, 0, 0, 0);
        add_row(1, 'h3060, 1, 1, 0, 0, wt, 4, rf, 7, 5, 0, 0, 0, 0);
        add_row(1, 'h3045, 1, 2, 0, 0, rd, 1, wt, 2, 5, 0, 1, 4, 1);
        add_row(1, 'h3065, 1, 3, 0, 0, wt, 4, rd, 2, 5, 0, 1, 5, 2);
        add_row(1, 'h3065, 0, 0, 0, 0, wt, 4, rf, 7, 5, 0, 1, 6, 3);
        add_row(1, 'h3060, 0, 0, 0, 0, wt, 4, rf, 7, 5, 0, 0, 0, 0);
        // Illegal opcode, r0 destination, nop and store take no tag.
        add_row(1, 'hF123, 0, 0, 0, 1, rf, 7, rf, 7, 5, 1, 0, 0, 0);
        add_row(1, 'h1012, 0, 0, 0, 0, rf, 7, rf, 7, 5, 0, 0, 0, 0);
        add_row(1, 'h0712, 0, 0, 0, 0, rf, 7, rf, 7, 5, 7, 0, 0, 0);
        add_row(1, 'h3012, 0, 0, 0, 0, rf, 7, rf, 7, 5, 0, 0, 0, 0);
        // Fill the buffer. Tags wrap from 6 back to 0.
        add_row(1, 'h1100, 0, 0, 0, 0, rf, 7, rf, 7, 5, 1, 0, 0, 0);
        add_row(1, 'h1200, 0, 0, 0, 0, rf, 7, rf, 7, 6, 2, 0, 0, 0);
        add_row(1, 'h1300, 0, 0, 0, 0, rf, 7, rf, 7, 0, 3, 0, 0, 0);
        add_row(1, 'h1400, 0, 0, 0, 0, rf, 7, rf, 7, 1, 4, 0, 0, 0);
        add_row(1, 'h1500, 0, 0, 0, 0, rf, 7, rf, 7, 2, 5, 0, 0, 0);
        add_row(1, 'h1712, 0, 0, 0, 0, wt, 5, wt, 6, 3, 7, 0, 0, 0);
        add_row(1, 'h1834, 1, 4, 1, 0, wt, 0, wt, 1, 4, 8, 0, 0, 0); // Eighth writer stalls.
        add_row(1, 'h1834, 0, 0, 1, 0, wt, 0, wt, 1, 4, 8, 1, 6, 4);
        add_row(1, 'h1834, 0, 0, 0, 0, wt, 0, wt, 1, 4, 8, 0, 0, 0);
        add_row(1, 'h3086, 0, 0, 0, 0, wt, 4, rf, 7, 5, 0, 0, 0, 0);
        add_row(0, 'h0000, 0, 0, 0, 0, rf, 7, rf, 7, 5, 0, 0, 0, 0);
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            cur_row = i;
            apply_row(rows[i]);
            #(clk_period - 2); // Sample just before the next edge.
            check_row(rows[i]);
            @(posedge clk);
            #1;
        end

        $display("=== PASS ===");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + reset_cycles + margin_cycles) * clk_period);
        $display("error: the run timed out before all table rows were applied");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: hw/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module inst_decode
    import rename_pkg::*;
(
    input  wire                      inst_valid,
    input  wire  [15:0]              inst,
    input  wire                      rob_full,
    output logic                     alloc,
    output logic                     stall,
    output logic                     illegal,
    output logic [`REG_ADDR_LEN-1:0] dest,
    output logic [`REG_ADDR_LEN-1:0] src1,
    output logic [`REG_ADDR_LEN-1:0] src2
);

    opcode_t opcode;
    logic    writes_dest;
    logic    reads_src1;
    logic    reads_src2;
    logic    known_op;
    logic    wants_alloc;

    always_comb begin
        opcode      = opcode_t'(inst[15:12]);
        writes_dest = 1'b0;
        reads_src1  = 1'b0;
        reads_src2  = 1'b0;
        known_op    = 1'b1;
        case (opcode)
            op_nop:   known_op = 1'b1;
            op_alu: begin
                writes_dest = 1'b1;
                reads_src1  = 1'b1;
                reads_src2  = 1'b1;
            end
            op_load: begin
                writes_dest = 1'b1;
                reads_src1  = 1'b1;
            end
            op_store: begin
                reads_src1  = 1'b1;
                reads_src2  = 1'b1;
            end
            default:  known_op = 1'b0;
        endcase
    end

    assign dest = inst[11:8];

    // An unused source points at r0, which is never renamed.
    assign src1 = reads_src1 ? inst[7:4] : '0;
    assign src2 = reads_src2 ? inst[3:0] : '0;

    // Writes to r0 are discarded, so they need no tag.
    assign wants_alloc = inst_valid && writes_dest && (dest != '0);
    assign alloc       = wants_alloc && !rob_full;
    assign stall       = wants_alloc && rob_full;
    assign illegal     = inst_valid && !known_op;

endmodule

`default_nettype wire

// File: hw/map_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module map_table
    import rename_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      alloc,
    input  wire  [`REG_ADDR_LEN-1:0] dest,
    input  wire  [`REG_ADDR_LEN-1:0] src1,
    input  wire  [`REG_ADDR_LEN-1:0] src2,
    input  wire  [`ROB_TAG_LEN-1:0]  alloc_tag,
    input  wire                      commit_valid,
    input  wire  [`REG_ADDR_LEN-1:0] commit_reg,
    input  wire  [`ROB_TAG_LEN-1:0]  commit_tag,
    input  wire                      cdb_valid,
    input  wire  [`REG_ADDR_LEN-1:0] cdb_reg,
    input  wire  [`ROB_TAG_LEN-1:0]  cdb_tag,
    output data_stat_t               src1_stat,
    output logic [`ROB_TAG_LEN-1:0]  src1_tag,
    output data_stat_t               src2_stat,
    output logic [`ROB_TAG_LEN-1:0]  src2_tag,
    output logic [`REG_ADDR_LEN-1:0] out_dest,
    output logic [`ROB_TAG_LEN-1:0]  out_tag
);

    // An entry holding NO_TAG means the value lives in the register file.
    logic [`ROB_TAG_LEN-1:0] tag_q [`REG_LEN];
    logic [`ROB_TAG_LEN-1:0] tag_d [`REG_LEN];
    logic [`REG_LEN-1:0]     ready_q;
    logic [`REG_LEN-1:0]     ready_d;

    function automatic data_stat_t lookup_stat(input logic [`REG_ADDR_LEN-1:0] addr);
        if (tag_q[addr] == `NO_TAG) begin
            return stat_in_regfile;
        end
        if (ready_q[addr]) begin
            return stat_ready_in_rob;
        end
        return stat_waiting;
    endfunction

    always_comb begin
        tag_d   = tag_q;
        ready_d = ready_q;

        // Release only if no younger producer has taken the register since.
        if (commit_valid && tag_q[commit_reg] == commit_tag) begin
            tag_d[commit_reg]   = `NO_TAG;
            ready_d[commit_reg] = 1'b0;
        end

        if (cdb_valid && tag_q[cdb_reg] == cdb_tag) begin
            ready_d[cdb_reg] = 1'b1;
        end

        // Applied last so a new mapping wins over a return to the same register.
        if (alloc) begin
            tag_d[dest]   = alloc_tag;
            ready_d[dest] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_LEN; i++) begin
                tag_q[i] <= `NO_TAG;
            end
            ready_q <= '0;
        end else begin
            tag_q   <= tag_d;
            ready_q <= ready_d;
        end
    end

    always_comb begin
        src1_stat = lookup_stat(src1);
        src2_stat = lookup_stat(src2);
        src1_tag  = tag_q[src1]; // Already NO_TAG when unmapped.
        src2_tag  = tag_q[src2];
    end

    assign out_dest = dest;
    assign out_tag  = alloc_tag;

    // Decode filters r0 writes, so r0 must stay unmapped for good.
    a_no_r0_alloc: assert property (
        @(posedge clk) disable iff (reset) alloc |-> dest != '0
    );

endmodule

`default_nettype wire

// File: hw/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// Architectural register file.
`define REG_ADDR_LEN 4
`define REG_LEN 16

// Reorder buffer tags. The all-ones tag is reserved to mean "no tag".
`define ROB_TAG_LEN 3
`define ROB_DEPTH ((1 << `ROB_TAG_LEN) - 1)
`define NO_TAG {`ROB_TAG_LEN{1'b1}}

`endif

// File: hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // Opcode field, bits 15 to 12 of the instruction word.
    typedef enum logic [3:0] {
        op_nop   = 4'h0, // No sources, no destination.
        op_alu   = 4'h1,
        op_load  = 4'h2, // Reads src1 only.
        op_store = 4'h3  // Reads both sources, writes nothing.
    } opcode_t;

    // Where a source operand can be found.
    typedef enum logic [1:0] {
        stat_in_regfile   = 2'b00,
        stat_waiting      = 2'b10,
        stat_ready_in_rob = 2'b11
    } data_stat_t;

endpackage

`default_nettype wire

// File: hw/rename_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module rename_top
    import rename_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      inst_valid,
    input  wire  [15:0]              inst,
    input  wire                      cdb_valid,
    input  wire  [`ROB_TAG_LEN-1:0]  cdb_tag,
    output logic                     stall,
    output logic                     illegal,
    output data_stat_t               src1_stat,
    output logic [`ROB_TAG_LEN-1:0]  src1_tag,
    output data_stat_t               src2_stat,
    output logic [`ROB_TAG_LEN-1:0]  src2_tag,
    output logic [`REG_ADDR_LEN-1:0] out_dest,
    output logic [`ROB_TAG_LEN-1:0]  out_tag,
    output logic                     commit_valid,
    output logic [`REG_ADDR_LEN-1:0] commit_reg,
    output logic [`ROB_TAG_LEN-1:0]  commit_tag
);

    logic                     alloc;
    logic                     rob_full;
    logic [`REG_ADDR_LEN-1:0] dest;
    logic [`REG_ADDR_LEN-1:0] src1;
    logic [`REG_ADDR_LEN-1:0] src2;
    logic [`ROB_TAG_LEN-1:0]  alloc_tag;
    logic [`REG_ADDR_LEN-1:0] cdb_reg;

    inst_decode u_decode (
        .inst_valid (inst_valid),
        .inst       (inst),
        .rob_full   (rob_full),
        .alloc      (alloc),
        .stall      (stall),
        .illegal    (illegal),
        .dest       (dest),
        .src1       (src1),
        .src2       (src2)
    );

    map_table u_map (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .dest         (dest),
        .src1         (src1),
        .src2         (src2),
        .alloc_tag    (alloc_tag),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag),
        .cdb_valid    (cdb_valid),
        .cdb_reg      (cdb_reg),
        .cdb_tag      (cdb_tag),
        .src1_stat    (src1_stat),
        .src1_tag     (src1_tag),
        .src2_stat    (src2_stat),
        .src2_tag     (src2_tag),
        .out_dest     (out_dest),
        .out_tag      (out_tag)
    );

    reorder_buffer u_rob (
        .clk          (clk),
        .reset        (reset),
        .alloc        (alloc),
        .dest         (dest),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .cdb_reg      (cdb_reg),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_tag   (commit_tag)
    );

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_config.svh"

module reorder_buffer (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      alloc,
    input  wire  [`REG_ADDR_LEN-1:0] dest,
    input  wire                      cdb_valid,
    input  wire  [`ROB_TAG_LEN-1:0]  cdb_tag,
    output logic [`ROB_TAG_LEN-1:0]  alloc_tag,
    output logic                     rob_full,
    output logic [`REG_ADDR_LEN-1:0] cdb_reg,
    output logic                     commit_valid,
    output logic [`REG_ADDR_LEN-1:0] commit_reg,
    output logic [`ROB_TAG_LEN-1:0]  commit_tag
);

    localparam int last_idx = `ROB_DEPTH - 1;

    logic [`REG_ADDR_LEN-1:0] entry_dest [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]    busy;
    logic [`ROB_DEPTH-1:0]    ready;
    logic [`ROB_TAG_LEN-1:0]  head;
    logic [`ROB_TAG_LEN-1:0]  tail;
    logic [`ROB_TAG_LEN-1:0]  count; // Holds 0 to ROB_DEPTH.

    // Pointers wrap before reaching the reserved NO_TAG value.
    function automatic logic [`ROB_TAG_LEN-1:0] next_ptr(input logic [`ROB_TAG_LEN-1:0] ptr);
        if (ptr == last_idx[`ROB_TAG_LEN-1:0]) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign alloc_tag    = tail; // The tag is the entry index.
    assign rob_full     = (count == `ROB_DEPTH);
    assign commit_valid = busy[head] && ready[head];
    assign commit_reg   = entry_dest[head];
    assign commit_tag   = head;
    assign cdb_reg      = (cdb_tag == `NO_TAG) ? '0 : entry_dest[cdb_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
            ready <= '0;
        end else begin
            if (alloc) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= next_ptr(tail);
            end
            if (cdb_valid && cdb_tag != `NO_TAG) begin
                ready[cdb_tag] <= 1'b1;
            end
            // Alloc never hits the head here, since the head is busy whenever it commits.
            if (commit_valid) begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                head        <= next_ptr(head);
            end
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_dest[tail] <= dest;
        end
    end

    // Decode must hold the instruction back while the buffer is full.
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (reset) alloc |-> !rob_full
    );

    a_cdb_tag_valid: assert property (
        @(posedge clk) disable iff (reset) cdb_valid |-> cdb_tag != `NO_TAG
    );

    // A broadcast has to come from an instruction still in flight.
    a_cdb_tag_busy: assert property (
        @(posedge clk) disable iff (reset)
        (cdb_valid && cdb_tag != `NO_TAG) |-> busy[cdb_tag]
    );

endmodule

`default_nettype wire
